// ==== sim.f ====
source/frontend_pkg.sv
source/pc_gen.sv
source/fetch_buffer.sv
source/parcel_aligner.sv
source/decode_stage.sv
source/front_end.sv
tests/tb_front_end.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_front_end -f sim.f

# The binary may stop early on an RTL assertion, so its output is kept
out=$(./obj_dir/Vtb_front_end || true)
echo "$out"
echo "$out" | grep -q "TB PASSED"

// ==== tests/tb_front_end.sv ====
/*
 * Testbench for the instruction front end: clock, reset, LFSR program image,
 * one-cycle memory model, redirect and stall stimulus, checking assertions
 */
`default_nettype none

module tb_front_end;

    localparam int RESET_CYCLES = 8;
    localparam int RUN_LEN      = 80;
    localparam int PHASE_LEN    = 24;
    localparam int N_REDIRECTS  = 7;
    localparam int N_STALLS     = 2;
    localparam int STALL_LEN    = 10;
    localparam int TOTAL_INSTRS = RUN_LEN + (N_REDIRECTS + N_STALLS) * PHASE_LEN;
    // Two cycles per instruction at worst, plus stalls and refill after redirects
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + 2 * TOTAL_INSTRS
                                  + N_STALLS * STALL_LEN + N_REDIRECTS * 8);

    logic clk_i;
    logic rst_n_i;
    logic exception_i;
    logic interrupt_i;
    logic handler_return_i;
    logic executed_i;
    logic taken_i;
    logic jump_i;
    logic flush_i;
    logic stall_i;
    logic fetch_o;
    logic mem_valid_i = 1'b0;
    frontend_pkg::xlen_t     mem_word_i = '0;
    frontend_pkg::xlen_t     handler_pc_i;
    frontend_pkg::xlen_t     handler_return_pc_i;
    frontend_pkg::xlen_t     branch_target_i;
    frontend_pkg::xlen_t     fetch_addr_o;
    frontend_pkg::dc_stage_t dc_o;

    // Program image as 256 parcels, i.e. 128 words that wrap every 512 bytes
    frontend_pkg::parcel_t   image [256];
    frontend_pkg::parcel_t   exp_lo;
    frontend_pkg::parcel_t   exp_hi;
    frontend_pkg::xlen_t     exp_pc;
    frontend_pkg::xlen_t     target_now;
    frontend_pkg::dc_stage_t exp_dc;
    logic [31:0]             lfsr = 32'h76a5;
    logic                    exp_mis;
    logic                    redirect_now;
    logic                    dc_ok;
    logic                    fetched = 1'b0;
    int                      cycle = 0;
    int                      checked;
    int                      value_errors = 0;
    int                      other_errors = 0;

    front_end #(
        .FETCH_BUFFER_DEPTH ( 4 )
    ) dut_i (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .exception_i         ( exception_i         ),
        .interrupt_i         ( interrupt_i         ),
        .handler_return_i    ( handler_return_i    ),
        .executed_i          ( executed_i          ),
        .taken_i             ( taken_i             ),
        .jump_i              ( jump_i              ),
        .flush_i             ( flush_i             ),
        .handler_pc_i        ( handler_pc_i        ),
        .handler_return_pc_i ( handler_return_pc_i ),
        .branch_target_i     ( branch_target_i     ),
        .stall_i             ( stall_i             ),
        .fetch_o             ( fetch_o             ),
        .fetch_addr_o        ( fetch_addr_o        ),
        .mem_valid_i         ( mem_valid_i         ),
        .mem_word_i          ( mem_word_i          ),
        .dc_o                ( dc_o                )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // ============================================================
    // Random source, program image and memory model
    // ============================================================

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
        end
        return v;
    endfunction

    // First 64 parcels hold only full instructions, the rest is a random mix
    task automatic build_image;
        int          p;
        logic [31:0] word;
        p = 0;
        while (p < 256) begin
            if (p >= 64 && (p == 255 || rand_bits(1) == 32'd1)) begin
                word = rand_bits(16);
                if (word[1:0] == 2'b11) begin
                    word[1:0] = 2'b10;
                end
                image[p] = word[15:0];
                p        = p + 1;
            end else begin
                word = rand_bits(32);
                case (rand_bits(2))
                    32'd0:   word[6:0] = frontend_pkg::OPCODE_BRANCH;
                    32'd1:   word[6:0] = frontend_pkg::OPCODE_JAL;
                    32'd2:   word[6:0] = frontend_pkg::OPCODE_JALR;
                    default: word[1:0] = 2'b11;
                endcase
                image[p]     = word[15:0];
                image[p + 1] = word[31:16];
                p            = p + 2;
            end
        end
    endtask

    always @(posedge clk_i) begin
        mem_valid_i <= fetch_o;
        mem_word_i  <= {image[{fetch_addr_o[8:2], 1'b1}], image[{fetch_addr_o[8:2], 1'b0}]};
    end

    // ============================================================
    // Expected stream
    // ============================================================

    assign redirect_now = exception_i | interrupt_i | handler_return_i
                        | (executed_i & (taken_i | jump_i)) | flush_i;

    always_comb begin
        if (exception_i || interrupt_i) begin
            target_now = handler_pc_i;
        end else if (handler_return_i) begin
            target_now = handler_return_pc_i;
        end else begin
            target_now = branch_target_i;
        end
    end

    // Next instruction from the image by the RISC-V length rule
    always_comb begin
        exp_lo            = image[exp_pc[8:1]];
        exp_hi            = image[exp_pc[8:1] + 8'd1];
        exp_dc            = '0;
        exp_dc.valid      = 1'b1;
        exp_dc.pc         = exp_pc;
        exp_dc.compressed = (exp_lo[1:0] != 2'b11);
        exp_dc.instr      = exp_dc.compressed ? {16'h0000, exp_lo} : {exp_hi, exp_lo};
        if (!exp_dc.compressed) begin
            exp_dc.rd     = exp_dc.instr[11:7];
            exp_dc.rs1    = exp_dc.instr[19:15];
            exp_dc.rs2    = exp_dc.instr[24:20];
            exp_dc.branch = (exp_dc.instr[6:0] == frontend_pkg::OPCODE_BRANCH);
            exp_dc.jump   = (exp_dc.instr[6:0] == frontend_pkg::OPCODE_JAL)
                          || (exp_dc.instr[6:0] == frontend_pkg::OPCODE_JALR);
        end
        exp_dc.exception = exp_mis;
        exp_dc.cause     = frontend_pkg::CAUSE_INSTR_MISALIGNED;
    end

    assign dc_ok = dc_o.pc == exp_dc.pc && dc_o.instr == exp_dc.instr
                && dc_o.compressed == exp_dc.compressed && dc_o.rs1 == exp_dc.rs1
                && dc_o.rs2 == exp_dc.rs2 && dc_o.rd == exp_dc.rd
                && dc_o.branch == exp_dc.branch && dc_o.jump == exp_dc.jump
                && dc_o.exception == exp_dc.exception
                && (!exp_dc.exception || dc_o.cause == exp_dc.cause);

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_pc  <= '0;
            exp_mis <= 1'b0;
            checked <= 0;
        end else if (redirect_now) begin
            exp_pc  <= target_now;
            exp_mis <= target_now[0];
        end else if (dc_o.valid && !stall_i) begin
            exp_pc  <= exp_pc + (exp_dc.compressed ? 32'd2 : 32'd4);
            checked <= checked + 1;
        end
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (rst_n_i && fetch_o) begin
            fetched <= 1'b1;
        end
        if (cycle >= TIMEOUT_CYCLES) begin
            other_errors++;
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            end_run();
        end
    end

    // ============================================================
    // Checks
    // ============================================================

    task automatic show_field(input string name, input logic [31:0] got,
                              input logic [31:0] want);
        if (got !== want) begin
            $display("Error %s: got 0x%0h expected 0x%0h", name, got, want);
        end
    endtask

    task automatic report_dc(input frontend_pkg::dc_stage_t got,
                             input frontend_pkg::dc_stage_t want);
        show_field("dc_o.pc", got.pc, want.pc);
        show_field("dc_o.instr", got.instr, want.instr);
        show_field("dc_o.compressed", got.compressed, want.compressed);
        show_field("dc_o.rs1", got.rs1, want.rs1);
        show_field("dc_o.rs2", got.rs2, want.rs2);
        show_field("dc_o.rd", got.rd, want.rd);
        show_field("dc_o.branch", got.branch, want.branch);
        show_field("dc_o.jump", got.jump, want.jump);
        show_field("dc_o.exception", got.exception, want.exception);
        if (want.exception) begin
            show_field("dc_o.cause", got.cause, want.cause);
        end
    endtask

    a_quiet_in_reset: assert property (@(posedge clk_i)
        (!rst_n_i && cycle != 0) |-> !fetch_o)
        else begin
            other_errors++;
            $display("fetch_o was high while reset was asserted");
        end

    a_first_fetch_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (fetch_o && !fetched) |-> fetch_addr_o == 32'd0)
        else begin
            value_errors++;
            $display("Error fetch_addr_o: got 0x%08h expected 0x00000000",
                     $sampled(fetch_addr_o));
        end

    a_quiet_before_fetch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !fetched |-> !dc_o.valid)
        else begin
            other_errors++;
            $display("dc_o.valid was high before the first fetch");
        end

    a_redirect_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        redirect_now |-> (fetch_o && fetch_addr_o == target_now))
        else begin
            value_errors++;
            $display("Error fetch_addr_o: got 0x%08h expected 0x%08h fetch_o 0x%0h",
                     $sampled(fetch_addr_o), $sampled(target_now), $sampled(fetch_o));
        end

    a_dc_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dc_o.valid |-> dc_ok)
        else begin
            value_errors++;
            report_dc($sampled(dc_o), $sampled(exp_dc));
        end

    a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (stall_i && !redirect_now) |=> $stable(dc_o))
        else begin
            other_errors++;
            $display("dc_o changed while stall_i was high");
        end

    // ============================================================
    // Stimulus
    // ============================================================

    task automatic wait_instrs(input int n);
        int goal;
        goal = checked + n;
        while (checked < goal) begin
            @(posedge clk_i);
        end
    endtask

    // Lines are exception, interrupt, handler return, executed, taken, jump, flush
    task automatic pulse_redirect(input logic [6:0] lines, input frontend_pkg::xlen_t hpc,
                                  input frontend_pkg::xlen_t rpc,
                                  input frontend_pkg::xlen_t bpc);
        @(posedge clk_i);
        {exception_i, interrupt_i, handler_return_i, executed_i,
         taken_i, jump_i, flush_i} <= lines;
        handler_pc_i        <= hpc;
        handler_return_pc_i <= rpc;
        branch_target_i     <= bpc;
        @(posedge clk_i);
        {exception_i, interrupt_i, handler_return_i, executed_i,
         taken_i, jump_i, flush_i} <= 7'b0;
        wait_instrs(PHASE_LEN);
    endtask

    task automatic stall_burst(input int len);
        @(posedge clk_i);
        stall_i <= 1'b1;
        repeat (len) @(posedge clk_i);
        stall_i <= 1'b0;
        wait_instrs(PHASE_LEN);
    endtask

    task automatic end_run;
        $display("Checked %0d instructions, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    initial begin
        rst_n_i             = 1'b0;
        exception_i         = 1'b0;
        interrupt_i         = 1'b0;
        handler_return_i    = 1'b0;
        executed_i          = 1'b0;
        taken_i             = 1'b0;
        jump_i              = 1'b0;
        flush_i             = 1'b0;
        stall_i             = 1'b0;
        handler_pc_i        = '0;
        handler_return_pc_i = '0;
        branch_target_i     = '0;
        build_image();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;
        // Full-only region first, then on into the mixed parcels
        wait_instrs(RUN_LEN);
        stall_burst(STALL_LEN);
        stall_burst(3);
        pulse_redirect(7'b1111111, 32'h100, 32'h080, 32'h1C0);
        pulse_redirect(7'b0011010, 32'h100, 32'h0C6, 32'h1C0);
        pulse_redirect(7'b0001101, 32'h100, 32'h080, 32'h15A);
        // Executed but neither taken nor a jump, so the stream goes on
        pulse_redirect(7'b0001000, 32'h100, 32'h080, 32'h020);
        pulse_redirect(7'b0110000, 32'h1F8, 32'h080, 32'h1C0);
        pulse_redirect(7'b0001010, 32'h100, 32'h080, 32'h0A1);
        pulse_redirect(7'b0001100, 32'h100, 32'h080, 32'h040);
        end_run();
    end

endmodule

`default_nettype wire

// ==== source/front_end.sv ====
/*
 * Instruction front end top level: pc generation, fetch buffer,
 * parcel aligner and decode stage with shared redirect and stall
 */
`default_nettype none

module front_end #(
    parameter int unsigned FETCH_BUFFER_DEPTH = 4
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    exception_i,
    input  logic                    interrupt_i,
    input  logic                    handler_return_i,
    input  logic                    executed_i,
    input  logic                    taken_i,
    input  logic                    jump_i,
    input  logic                    flush_i,
    input  frontend_pkg::xlen_t     handler_pc_i,
    input  frontend_pkg::xlen_t     handler_return_pc_i,
    input  frontend_pkg::xlen_t     branch_target_i,
    input  logic                    stall_i,
    output logic                    fetch_o,
    output frontend_pkg::xlen_t     fetch_addr_o,
    input  logic                    mem_valid_i,
    input  frontend_pkg::xlen_t     mem_word_i,
    output frontend_pkg::dc_stage_t dc_o
);

    frontend_pkg::fetch_word_t head;
    frontend_pkg::if_stage_t   if_stage;

    logic redirect;
    logic buffer_full;
    logic buffer_empty;
    logic pop;

    // ============================================================
    // PC generation and fetch buffer
    // ============================================================

    pc_gen u_pc_gen (
        .clk_i               ( clk_i               ),
        .rst_n_i             ( rst_n_i             ),
        .exception_i         ( exception_i         ),
        .interrupt_i         ( interrupt_i         ),
        .handler_return_i    ( handler_return_i    ),
        .executed_i          ( executed_i          ),
        .taken_i             ( taken_i             ),
        .jump_i              ( jump_i              ),
        .flush_i             ( flush_i             ),
        .handler_pc_i        ( handler_pc_i        ),
        .handler_return_pc_i ( handler_return_pc_i ),
        .branch_target_i     ( branch_target_i     ),
        .buffer_full_i       ( buffer_full         ),
        .fetch_o             ( fetch_o             ),
        .fetch_addr_o        ( fetch_addr_o        ),
        .redirect_o          ( redirect            )
    );

    fetch_buffer #(
        .FETCH_BUFFER_DEPTH ( FETCH_BUFFER_DEPTH )
    ) u_fetch_buffer (
        .clk_i        ( clk_i        ),
        .rst_n_i      ( rst_n_i      ),
        .flush_i      ( redirect     ),
        .fetch_i      ( fetch_o      ),
        .fetch_addr_i ( fetch_addr_o ),
        .mem_valid_i  ( mem_valid_i  ),
        .mem_word_i   ( mem_word_i   ),
        .pop_i        ( pop          ),
        .head_o       ( head         ),
        .empty_o      ( buffer_empty ),
        .full_o       ( buffer_full  )
    );

    // ============================================================
    // Fetch and decode stages
    // ============================================================

    parcel_aligner u_parcel_aligner (
        .clk_i   ( clk_i        ),
        .rst_n_i ( rst_n_i      ),
        .flush_i ( redirect     ),
        .stall_i ( stall_i      ),
        .head_i  ( head         ),
        .empty_i ( buffer_empty ),
        .pop_o   ( pop          ),
        .if_o    ( if_stage     )
    );

    decode_stage u_decode_stage (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .flush_i ( redirect ),
        .stall_i ( stall_i  ),
        .if_i    ( if_stage ),
        .dc_o    ( dc_o     )
    );

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
/*
 * Reduced decode: register fields, branch and jump class,
 * exception merge and the decode-stage register
 */
`default_nettype none

module decode_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  logic                    stall_i,
    input  frontend_pkg::if_stage_t if_i,
    output frontend_pkg::dc_stage_t dc_o
);

    frontend_pkg::dc_stage_t dc_q;
    frontend_pkg::reg_idx_t  rs1;
    frontend_pkg::reg_idx_t  rs2;
    frontend_pkg::reg_idx_t  rd;
    logic [6:0]              opcode;
    logic                    full;
    logic                    illegal;

    assign opcode = if_i.instr.fields.opcode;
    assign full   = ~if_i.compressed;

    // Compressed parcels leave unexpanded, so no registers are reported for them
    assign rs1 = full ? if_i.instr.fields.rs1 : '0;
    assign rs2 = full ? if_i.instr.fields.rs2 : '0;
    assign rd  = full ? if_i.instr.fields.rd : '0;

    assign illegal = full & (opcode[1:0] != 2'b11);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            dc_q.valid <= 1'b0;
        end else if (!stall_i) begin
            dc_q.valid <= if_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dc_q.pc         <= if_i.pc;
            dc_q.instr      <= if_i.instr;
            dc_q.compressed <= if_i.compressed;
            dc_q.rs1        <= rs1;
            dc_q.rs2        <= rs2;
            dc_q.rd         <= rd;
            dc_q.branch     <= full & (opcode == frontend_pkg::OPCODE_BRANCH);
            dc_q.jump       <= full & ((opcode == frontend_pkg::OPCODE_JAL)
                                    || (opcode == frontend_pkg::OPCODE_JALR));
            dc_q.exception  <= if_i.misaligned | illegal;
            // Misaligned fetch takes precedence over the opcode check
            dc_q.cause      <= if_i.misaligned ? frontend_pkg::CAUSE_INSTR_MISALIGNED
                                               : frontend_pkg::CAUSE_INSTR_ILLEGAL;
        end
    end

    assign dc_o = dc_q;

    // The aligner only ever hands over full instructions with both low bits set
    a_full_opcode: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (if_i.valid && full) |-> (opcode[1:0] == 2'b11))
        else $error("decode_stage: full instruction opcode 0x%0h at pc 0x%08h",
                    opcode, if_i.pc);

endmodule

`default_nettype wire

// ==== source/parcel_aligner.sv ====
/*
 * Parcel aligner: splits buffered words into compressed and full
 * instructions, fuses instructions that cross a word, fetch-stage register
 */
`default_nettype none

module parcel_aligner (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      stall_i,
    input  frontend_pkg::fetch_word_t head_i,
    input  logic                      empty_i,
    output logic                      pop_o,
    output frontend_pkg::if_stage_t   if_o
);

    frontend_pkg::instr_word_u head_word;
    frontend_pkg::instr_word_u instr;
    frontend_pkg::parcel_t     upper_q;
    frontend_pkg::xlen_t       base_pc;
    frontend_pkg::xlen_t       instr_pc;
    frontend_pkg::if_stage_t   if_q;

    logic sel_upper_q;
    logic cross_q;
    logic first_q;
    logic sel_upper;
    logic active;
    logic lower_compressed;
    logic upper_full;
    logic lower_done;
    logic emit;
    logic compressed;

    assign head_word = head_i.word;
    assign active    = ~empty_i & ~stall_i;

    // A target with bit 1 set begins on the upper parcel of its first word
    assign sel_upper = sel_upper_q | (first_q & head_i.addr[1] & ~cross_q);

    assign lower_compressed = (head_word.parcels.lower[1:0] != 2'b11);
    assign upper_full       = (head_word.parcels.upper[1:0] == 2'b11);

    // Lower parcel used alone, upper parcel still to be handled
    assign lower_done = ~sel_upper & (cross_q | lower_compressed);

    // ============================================================
    // Instruction selection
    // ============================================================

    always_comb begin
        instr      = head_word;
        compressed = 1'b0;
        emit       = 1'b1;
        if (cross_q) begin
            instr.parcels.upper = head_word.parcels.lower;
            instr.parcels.lower = upper_q;
        end else if (sel_upper) begin
            instr.parcels.upper = '0;
            instr.parcels.lower = head_word.parcels.upper;
            compressed          = ~upper_full;
            // A full instruction here waits for the next word
            emit                = ~upper_full;
        end else if (lower_compressed) begin
            instr.parcels.upper = '0;
            compressed          = 1'b1;
        end
    end

    // Low bits keep the fetched bit 0 so a misaligned target stays visible
    assign base_pc = {head_i.addr[31:2], 1'b0, head_i.addr[0]};

    always_comb begin
        if (cross_q) begin
            instr_pc = base_pc - 32'd2;
        end else if (sel_upper) begin
            instr_pc = base_pc + 32'd2;
        end else begin
            instr_pc = base_pc;
        end
    end

    // The word stays at the head only while its upper compressed parcel is pending
    assign pop_o = active & ~(lower_done & ~upper_full);

    // ============================================================
    // Aligner state and fetch-stage register
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            sel_upper_q <= 1'b0;
            cross_q     <= 1'b0;
            first_q     <= 1'b1;
        end else if (active) begin
            sel_upper_q <= lower_done & ~upper_full;
            cross_q     <= (lower_done | sel_upper) & upper_full;
            if (pop_o) begin
                first_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (active && upper_full) begin
            upper_q <= head_word.parcels.upper;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            if_q.valid <= 1'b0;
        end else if (!stall_i) begin
            if_q.valid <= ~empty_i & emit;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            if_q.instr      <= instr;
            if_q.pc         <= instr_pc;
            if_q.compressed <= compressed;
            if_q.misaligned <= head_i.addr[0];
        end
    end

    assign if_o = if_q;

endmodule

`default_nettype wire

// ==== source/fetch_buffer.sv ====
/*
 * Fetch buffer: request addresses reserved at fetch time,
 * memory words filled on response, head presented to the aligner
 */
`default_nettype none

module fetch_buffer #(
    parameter int unsigned FETCH_BUFFER_DEPTH = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      flush_i,
    input  logic                      fetch_i,
    input  frontend_pkg::xlen_t       fetch_addr_i,
    input  logic                      mem_valid_i,
    input  frontend_pkg::xlen_t       mem_word_i,
    input  logic                      pop_i,
    output frontend_pkg::fetch_word_t head_o,
    output logic                      empty_o,
    output logic                      full_o
);

    localparam int unsigned PTR_W = $clog2(FETCH_BUFFER_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    frontend_pkg::xlen_t addr_q [FETCH_BUFFER_DEPTH];
    frontend_pkg::xlen_t word_q [FETCH_BUFFER_DEPTH];

    logic [FETCH_BUFFER_DEPTH-1:0] filled_q;
    logic [PTR_W-1:0]              rsv_ptr_q;
    logic [PTR_W-1:0]              fill_ptr_q;
    logic [PTR_W-1:0]              rd_ptr_q;
    logic [CNT_W-1:0]              count_q;
    logic [PTR_W-1:0]              rsv_idx;

    // A redirect fetch restarts the buffer at slot zero
    assign rsv_idx = flush_i ? '0 : rsv_ptr_q;

    always_ff @(posedge clk_i) begin
        if (fetch_i) begin
            addr_q[rsv_idx] <= fetch_addr_i;
        end
        if (mem_valid_i && !flush_i) begin
            word_q[fill_ptr_q] <= mem_word_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            filled_q   <= '0;
            rsv_ptr_q  <= '0;
            fill_ptr_q <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
        end else if (flush_i) begin
            // Words still in flight belong to the old stream and are dropped
            filled_q   <= '0;
            rsv_ptr_q  <= PTR_W'(fetch_i);
            fill_ptr_q <= '0;
            rd_ptr_q   <= '0;
            count_q    <= CNT_W'(fetch_i);
        end else begin
            if (fetch_i) begin
                rsv_ptr_q <= rsv_ptr_q + 1'b1;
            end
            if (pop_i) begin
                filled_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q           <= rd_ptr_q + 1'b1;
            end
            if (mem_valid_i) begin
                filled_q[fill_ptr_q] <= 1'b1;
                fill_ptr_q           <= fill_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(fetch_i) - CNT_W'(pop_i);
        end
    end

    assign head_o  = '{addr: addr_q[rd_ptr_q], word: word_q[rd_ptr_q]};
    assign empty_o = ~filled_q[rd_ptr_q];
    assign full_o  = (count_q == CNT_W'(FETCH_BUFFER_DEPTH));

    a_no_fetch_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (fetch_i && !flush_i) |-> !full_o)
        else $error("fetch_buffer: slot reserved while full, count 0x%0h", count_q);

    a_no_pop_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o)
        else $error("fetch_buffer: pop while empty");

endmodule

`default_nettype wire

// ==== source/pc_gen.sv ====
/*
 * Program counter register and next fetch address selection
 */
`default_nettype none

module pc_gen (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                exception_i,
    input  logic                interrupt_i,
    input  logic                handler_return_i,
    input  logic                executed_i,
    input  logic                taken_i,
    input  logic                jump_i,
    input  logic                flush_i,
    input  frontend_pkg::xlen_t handler_pc_i,
    input  frontend_pkg::xlen_t handler_return_pc_i,
    input  frontend_pkg::xlen_t branch_target_i,
    input  logic                buffer_full_i,
    output logic                fetch_o,
    output frontend_pkg::xlen_t fetch_addr_o,
    output logic                redirect_o
);

    frontend_pkg::xlen_t pc_q;
    logic                run_q;
    logic                resolved_taken;

    // An executed branch that falls through keeps the sequential stream
    assign resolved_taken = executed_i & (taken_i | jump_i);
    assign redirect_o = exception_i | interrupt_i | handler_return_i
                      | resolved_taken | flush_i;

    // Sequential fetching only starts the cycle after reset is released
    assign fetch_o = redirect_o | (run_q & ~buffer_full_i);

    always_comb begin
        if (exception_i || interrupt_i) begin
            fetch_addr_o = handler_pc_i;
        end else if (handler_return_i) begin
            fetch_addr_o = handler_return_pc_i;
        end else if (resolved_taken) begin
            fetch_addr_o = branch_target_i;
        end else begin
            fetch_addr_o = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q  <= frontend_pkg::RESET_PC;
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (fetch_o) begin
                pc_q <= fetch_addr_o;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frontend_pkg.sv ====
/*
 * Shared front end types: word widths, the instruction word union,
 * the fetch, fetch-stage and decode-stage bundles, opcode and cause constants
 */
`default_nettype none

package frontend_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [15:0] parcel_t;
    typedef logic [4:0]  reg_idx_t;

    // One 32-bit word seen as two parcels or as the base R-type fields
    typedef union packed {
        struct packed {
            parcel_t upper;
            parcel_t lower;
        } parcels;
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } fields;
    } instr_word_u;

    // Memory word together with the address that requested it
    typedef struct packed {
        xlen_t addr;
        xlen_t word;
    } fetch_word_t;

    typedef struct packed {
        logic        valid;
        instr_word_u instr;
        xlen_t       pc;
        logic        compressed;
        logic        misaligned;
    } if_stage_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        xlen_t      instr;
        logic       compressed;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       branch;
        logic       jump;
        logic       exception;
        logic [4:0] cause;
    } dc_stage_t;

    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    localparam logic [4:0] CAUSE_INSTR_MISALIGNED = 5'd0;
    localparam logic [4:0] CAUSE_INSTR_ILLEGAL    = 5'd2;

    // The first sequential step lands on address zero
    localparam xlen_t RESET_PC = 32'hFFFF_FFFC;

endpackage

`default_nettype wire
